// File: jtag_monitor.f
+incdir+verilog
verilog/jtag_mon_pkg.sv
verilog/jtag_pad_sync.sv
verilog/jtag_tap.sv
verilog/capture_bank.sv
verilog/mon_ctrl_regs.sv
verilog/display_compose.sv
verilog/digit_scan.sv
verilog/jtag_monitor.sv
tb/jtag_mon_checker.sv
tb/tb_jtag_monitor.sv

// File: tb/jtag_mon_checker.sv
`timescale 1ns/100ps
`include "jtag_mon_cfg.svh"

module jtag_mon_checker (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     tck,
    input  logic                     tms,
    input  logic                     tdi,
    input  jtag_mon_pkg::cfg_wr_t    cfg,
    input  logic                     scan_start,
    input  logic                     tdo,
    input  jtag_mon_pkg::tap_state_e tap_state,
    input  jtag_mon_pkg::digit_t     digit,
    output int                       errors
);
    import jtag_mon_pkg::*;

    localparam int NUM_DIGITS = `ROW_DIGITS * `DISPLAY_ROWS;

    tap_state_e               m_state;
    logic [`IR_LEN-1:0]       m_ir;
    logic [`IR_LEN-1:0]       m_ir_sr;
    logic [31:0]              m_dr;
    logic                     m_bypass;
    logic                     m_tdo;    // pin value expected until the next rise
    logic [31:0]              m_idcode;
    logic                     m_freeze;
    logic [`CAPTURE_BITS-1:0] rec_tms;
    logic [`CAPTURE_BITS-1:0] rec_tdi;
    logic [`CAPTURE_BITS-1:0] rec_tdo;
    logic [3:0]               expect_nib [NUM_DIGITS];
    logic                     tck_prev;
    logic                     fresh;    // first cycle out of reset
    logic                     scanning;
    int                       scan_idx;

    task automatic note_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        errors++;
        $display("Mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    endtask

    task automatic protocol_error(input string what);
        errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    // {next with TMS high, next with TMS low}
    function automatic tap_state_e tap_next(input tap_state_e s, input logic tms_v);
        logic [7:0] pair;
        case (s)
            TEST_LOGIC_RESET: pair = {TEST_LOGIC_RESET, RUN_TEST_IDLE};
            RUN_TEST_IDLE:    pair = {SELECT_DR_SCAN, RUN_TEST_IDLE};
            SELECT_DR_SCAN:   pair = {SELECT_IR_SCAN, CAPTURE_DR};
            CAPTURE_DR:       pair = {EXIT1_DR, SHIFT_DR};
            SHIFT_DR:         pair = {EXIT1_DR, SHIFT_DR};
            EXIT1_DR:         pair = {UPDATE_DR, PAUSE_DR};
            PAUSE_DR:         pair = {EXIT2_DR, PAUSE_DR};
            EXIT2_DR:         pair = {UPDATE_DR, SHIFT_DR};
            UPDATE_DR:        pair = {SELECT_DR_SCAN, RUN_TEST_IDLE};
            SELECT_IR_SCAN:   pair = {TEST_LOGIC_RESET, CAPTURE_IR};
            CAPTURE_IR:       pair = {EXIT1_IR, SHIFT_IR};
            SHIFT_IR:         pair = {EXIT1_IR, SHIFT_IR};
            EXIT1_IR:         pair = {UPDATE_IR, PAUSE_IR};
            PAUSE_IR:         pair = {EXIT2_IR, PAUSE_IR};
            EXIT2_IR:         pair = {UPDATE_IR, SHIFT_IR};
            UPDATE_IR:        pair = {SELECT_DR_SCAN, RUN_TEST_IDLE};
            default:          pair = {TEST_LOGIC_RESET, TEST_LOGIC_RESET};
        endcase
        return tap_state_e'(tms_v ? pair[7:4] : pair[3:0]);
    endfunction

    // row 0 is state plus TDI bits, rows 1..3 are records in hex
    function automatic logic [3:0] layout_nibble(input int row, input int col);
        int top;
        top = `CAPTURE_BITS - 1 - 4 * col;
        case (row)
            0: layout_nibble = (col == 0) ? 4'(m_state)
                                          : {3'b000, rec_tdi[`ROW_DIGITS - 1 - col]};
            1: layout_nibble = rec_tms[top -: 4];
            2: layout_nibble = rec_tdi[top -: 4];
            default: layout_nibble = rec_tdo[top -: 4];
        endcase
    endfunction

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            m_state  = TEST_LOGIC_RESET;
            m_ir     = IR_IDCODE;
            m_ir_sr  = '0;
            m_dr     = '0;
            m_bypass = 1'b0;
            m_tdo    = 1'b0;
            m_idcode = `IDCODE_RESET;
            m_freeze = 1'b0;
            rec_tms  = '0;
            rec_tdi  = '0;
            rec_tdo  = '0;
            tck_prev = 1'b0;
            fresh    = 1'b1;
            scanning = 1'b0;
            scan_idx = 0;
            errors   = 0;
        end else begin
            if (fresh && (tap_state !== TEST_LOGIC_RESET || tdo !== 1'b0 || digit.valid !== 1'b0))
                protocol_error("outputs not at their reset values after reset");
            fresh = 1'b0;
            if (cfg.wr && cfg.addr == CFG_IDCODE)
                m_idcode = cfg.wdata;
            if (cfg.wr && cfg.addr == CFG_CTRL) begin
                m_freeze = cfg.wdata[0];
                if (cfg.wdata[1]) begin
                    rec_tms = '0;
                    rec_tdi = '0;
                    rec_tdo = '0;
                end
            end
            if (tck && !tck_prev) begin
                if (tdo !== m_tdo)
                    note_mismatch("tdo", tdo, m_tdo);
                if (!m_freeze) begin
                    rec_tms = {rec_tms[`CAPTURE_BITS-2:0], tms};
                    rec_tdi = {rec_tdi[`CAPTURE_BITS-2:0], tdi};
                    rec_tdo = {rec_tdo[`CAPTURE_BITS-2:0], m_tdo};
                end
                case (m_state)
                    CAPTURE_IR: m_ir_sr = {{(`IR_LEN-1){1'b0}}, 1'b1};
                    SHIFT_IR:   m_ir_sr = {tdi, m_ir_sr[`IR_LEN-1:1]};
                    UPDATE_IR:  m_ir = m_ir_sr;
                    CAPTURE_DR: begin
                        m_dr     = m_idcode;
                        m_bypass = 1'b0;
                    end
                    SHIFT_DR: begin
                        if (m_ir == IR_IDCODE)
                            m_dr = {tdi, m_dr[31:1]};
                        else
                            m_bypass = tdi; // any other code is bypass
                    end
                    default: ;
                endcase
                m_state = tap_next(m_state, tms);
                if (m_state == TEST_LOGIC_RESET)
                    m_ir = IR_IDCODE;
            end
            if (!tck && tck_prev) begin
                if (tap_state !== m_state)
                    note_mismatch("tap_state", tap_state, m_state);
                if (m_state == SHIFT_DR)
                    m_tdo = (m_ir == IR_IDCODE) ? m_dr[0] : m_bypass;
                else if (m_state == SHIFT_IR)
                    m_tdo = m_ir_sr[0];
                else
                    m_tdo = 1'b0;
            end
            tck_prev = tck;
            if (scanning && digit.valid) begin
                if (scan_idx >= NUM_DIGITS) begin
                    protocol_error("scan kept running past the last digit");
                end else begin
                    if ({digit.row, digit.col} !== 6'(scan_idx))
                        note_mismatch($sformatf("digit %0d position", scan_idx),
                                      {digit.row, digit.col}, scan_idx);
                    if (digit.nibble !== expect_nib[scan_idx])
                        note_mismatch($sformatf("digit %0d value", scan_idx),
                                      digit.nibble, expect_nib[scan_idx]);
                end
                scan_idx++;
            end else if (scanning) begin
                if (scan_idx != NUM_DIGITS)
                    protocol_error($sformatf("scan gave %0d digits instead of %0d",
                                             scan_idx, NUM_DIGITS));
                scanning = 1'b0;
            end else if (digit.valid) begin
                protocol_error("digit valid while no scan was started");
            end
            if (scan_start && !scanning) begin
                for (int k = 0; k < NUM_DIGITS; k++)
                    expect_nib[k] = layout_nibble(k / `ROW_DIGITS, k % `ROW_DIGITS);
                scanning = 1'b1;
                scan_idx = 0;
            end
        end
    end

endmodule

// File: tb/tb_jtag_monitor.sv
`timescale 1ns/100ps
`include "jtag_mon_cfg.svh"

module tb_jtag_monitor;
    import jtag_mon_pkg::*;

    // TCK count of tests 1, 2, 3 (longest case), 4 and 6, each TCK is 8 clocks
    localparam int TCK_TOTAL      = 43 + 37 + 79 + 60 + 20;
    localparam int SCAN_CYCLES    = 3 * (`ROW_DIGITS * `DISPLAY_ROWS + 8);
    localparam int TIMEOUT_CYCLES = TCK_TOTAL * 8 + SCAN_CYCLES + 300;

    logic        clk;
    logic        arst_n;
    logic        tck;
    logic        tms;
    logic        tdi;
    cfg_wr_t     cfg;
    logic        scan_start;
    logic        tdo;
    tap_state_e  tap_state;
    digit_t      digit;
    int          errors;        // running total from the checker
    int          errors_before;
    int          tests_run;
    int          tests_failed;
    int          cycles;
    int          n;
    logic [15:0] lfsr;
    logic [63:0] rnd;

    jtag_monitor uut (.*);

    jtag_mon_checker chk (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int count, output logic [63:0] v);
        v = '0;
        for (int i = 0; i < count; i++) begin
            lfsr = lfsr_next(lfsr);
            v[i] = lfsr[0];
        end
    endtask

    // called on a falling clk edge, returns on one
    task automatic jtag_clock(input logic tms_v, input logic tdi_v);
        tck = 1'b0;
        tms = tms_v;
        tdi = tdi_v;
        repeat (4) @(negedge clk);
        tck = 1'b1;
        repeat (4) @(negedge clk);
    endtask

    // run-test/idle through one DR or IR scan and back to idle
    task automatic scan_chain(input logic is_ir, input int len, input logic [63:0] data);
        jtag_clock(1'b1, 1'b0);
        if (is_ir)
            jtag_clock(1'b1, 1'b0);
        jtag_clock(1'b0, 1'b0); // capture
        jtag_clock(1'b0, 1'b0); // into shift
        for (int i = 0; i < len; i++)
            jtag_clock(i == len - 1, data[i]); // exit1 with the last bit
        jtag_clock(1'b1, 1'b0);
        jtag_clock(1'b0, 1'b0);
    endtask

    task automatic random_walk(input int steps);
        logic [63:0] v;
        for (int i = 0; i < steps; i++) begin
            take_bits(2, v);
            jtag_clock(v[0], v[1]);
        end
    endtask

    task automatic write_reg(input cfg_reg_e addr, input logic [31:0] data);
        cfg.wr    = 1'b1;
        cfg.addr  = addr;
        cfg.wdata = data;
        @(negedge clk);
        cfg = '0;
        repeat (3) @(negedge clk); // clear lands two cycles later
    endtask

    task automatic run_scan();
        scan_start = 1'b1;
        @(negedge clk);
        scan_start = 1'b0;
        while (!digit.valid)
            @(negedge clk);
        while (digit.valid)
            @(negedge clk);
        repeat (2) @(negedge clk);
    endtask

    // park TCK low so the last state gets compared, then report
    task automatic end_test(input string name);
        tck = 1'b0;
        repeat (4) @(negedge clk);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests_run, name, errors - errors_before);
        end
        errors_before = errors;
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("run stopped: tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        arst_n        = 1'b0;
        tck           = 1'b0;
        tms           = 1'b0;
        tdi           = 1'b0;
        cfg           = '0;
        scan_start    = 1'b0;
        lfsr          = 16'd1631;
        errors_before = 0;
        tests_run     = 0;
        tests_failed  = 0;
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        repeat (2) @(negedge clk);

        repeat (5) jtag_clock(1'b1, 1'b0);
        jtag_clock(1'b0, 1'b0); // idle
        scan_chain(1'b0, 32, 64'd0);
        end_test("idcode after reset");

        take_bits(32, rnd);
        write_reg(CFG_IDCODE, rnd[31:0]);
        scan_chain(1'b0, 32, 64'd0);
        end_test("idcode after write");

        scan_chain(1'b1, `IR_LEN, 64'(IR_BYPASS));
        take_bits(5, rnd);
        n = 33 + int'(rnd[4:0]);
        take_bits(n, rnd);
        scan_chain(1'b0, n, rnd);
        end_test("bypass delay");

        random_walk(60);
        end_test("tms walk");

        run_scan();
        end_test("display scan");

        write_reg(CFG_CTRL, 32'h1);
        random_walk(20);
        run_scan();
        end_test("frozen capture");

        write_reg(CFG_CTRL, 32'h2); // unfreeze, clear records
        run_scan();
        end_test("capture clear");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: verilog/capture_bank.sv
`timescale 1ns/100ps
`include "jtag_mon_cfg.svh"

module capture_bank (
    input  logic                      clk,
    input  logic                      arst_n,
    input  jtag_mon_pkg::jtag_sample_t smp,
    input  logic                      tdo,
    input  logic                      freeze,
    input  logic                      clear,
    output jtag_mon_pkg::capture_t    cap
);

    localparam int DEPTH = `CAPTURE_BITS;

    // three parallel records stepped by the rise strobe, not by TCK
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cap <= '0;
        end else if (clear) begin
            cap <= '0; // wins over freeze too
        end else if (smp.tck_rise && !freeze) begin
            cap.tms <= {cap.tms[DEPTH-2:0], smp.tms};
            cap.tdi <= {cap.tdi[DEPTH-2:0], smp.tdi};
            cap.tdo <= {cap.tdo[DEPTH-2:0], tdo}; // value on the pin at the rise
        end
    end

endmodule

// File: verilog/digit_scan.sv
`timescale 1ns/100ps
`include "jtag_mon_cfg.svh"

module digit_scan (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic [`DISPLAY_BITS-1:0] display,
    input  logic                     scan_start,
    output jtag_mon_pkg::digit_t     digit
);

    localparam int ROW_BITS = `ROW_DIGITS * 4;
    localparam int COL_W    = $clog2(`ROW_DIGITS);
    localparam int IDX_W    = $clog2(`ROW_DIGITS * `DISPLAY_ROWS);

    logic [`DISPLAY_BITS-1:0] snap;
    logic [IDX_W-1:0]         idx; // {row, col}
    logic                     busy;
    logic [IDX_W+1:0]         nib_base;

    always_ff @(posedge clk) begin
        if (scan_start && !busy)
            snap <= display;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            idx  <= '0;
        end else if (!busy) begin
            if (scan_start) begin
                busy <= 1'b1;
                idx  <= '0;
            end
        end else begin
            idx <= idx + 1'b1;
            if (idx == '1)
                busy <= 1'b0; // last digit out
        end
    end

    // row base plus column offset counted down from the row's top nibble
    assign nib_base = {idx[IDX_W-1:COL_W], {$clog2(ROW_BITS){1'b0}}}
                    + (IDX_W+2)'(ROW_BITS - 4)
                    - {idx[COL_W-1:0], 2'b00};

    assign digit.valid  = busy;
    assign digit.row    = idx[IDX_W-1:COL_W];
    assign digit.col    = idx[COL_W-1:0];
    assign digit.nibble = snap[nib_base +: 4];

endmodule

// File: verilog/display_compose.sv
`timescale 1ns/100ps
`include "jtag_mon_cfg.svh"

module display_compose (
    input  jtag_mon_pkg::capture_t   cap,
    input  jtag_mon_pkg::tap_state_e tap_state,
    output logic [`DISPLAY_BITS-1:0] display
);

    localparam int ROW_BITS = `ROW_DIGITS * 4;

    // digit 0 of a row sits in the top nibble of that row's slice
    always_comb begin
        display = '0;

        // row 0: state code, then TDI as binary with the newest bit rightmost
        display[ROW_BITS-1 -: 4] = tap_state;
        for (int j = 0; j < `ROW_DIGITS - 1; j++) begin
            display[4*j +: 4] = {3'b000, cap.tdi[j]};
        end

        // rows 1..3 in hex, record bits 63:60 in digit 0
        display[1*ROW_BITS +: ROW_BITS] = cap.tms;
        display[2*ROW_BITS +: ROW_BITS] = cap.tdi;
        display[3*ROW_BITS +: ROW_BITS] = cap.tdo;
    end

endmodule

// File: verilog/jtag_mon_cfg.svh
`ifndef JTAG_MON_CFG_SVH
`define JTAG_MON_CFG_SVH

// depth of each TMS/TDI/TDO record
`define CAPTURE_BITS 64

// display shape, 4 bits per hex digit
`define ROW_DIGITS   16
`define DISPLAY_ROWS 4
`define DISPLAY_BITS (`DISPLAY_ROWS * `ROW_DIGITS * 4)

// instruction register length
`define IR_LEN 4

// IDCODE after reset, bit 0 set as JTAG requires
`define IDCODE_RESET 32'h0A5C_3E1B

`endif

// File: verilog/jtag_mon_pkg.sv
`include "jtag_mon_cfg.svh"

package jtag_mon_pkg;

    // standard TAP state encoding
    typedef enum logic [3:0] {
        EXIT2_DR         = 4'h0,
        EXIT1_DR         = 4'h1,
        SHIFT_DR         = 4'h2,
        PAUSE_DR         = 4'h3,
        SELECT_IR_SCAN   = 4'h4,
        UPDATE_DR        = 4'h5,
        CAPTURE_DR       = 4'h6,
        SELECT_DR_SCAN   = 4'h7,
        EXIT2_IR         = 4'h8,
        EXIT1_IR         = 4'h9,
        SHIFT_IR         = 4'hA,
        PAUSE_IR         = 4'hB,
        RUN_TEST_IDLE    = 4'hC,
        UPDATE_IR        = 4'hD,
        CAPTURE_IR       = 4'hE,
        TEST_LOGIC_RESET = 4'hF
    } tap_state_e;

    // unknown codes select the bypass register
    typedef enum logic [`IR_LEN-1:0] {
        IR_IDCODE = {{(`IR_LEN-1){1'b0}}, 1'b1},
        IR_BYPASS = {`IR_LEN{1'b1}}
    } ir_op_e;

    typedef enum logic [1:0] {
        CFG_CTRL   = 2'd0, // bit 0 freeze, bit 1 clear
        CFG_IDCODE = 2'd1
    } cfg_reg_e;

    typedef struct packed {
        logic tck_rise;
        logic tck_fall;
        logic tms;
        logic tdi;
    } jtag_sample_t;

    typedef struct packed {
        logic        wr;
        cfg_reg_e    addr;
        logic [31:0] wdata;
    } cfg_wr_t;

    // newest bit at bit 0
    typedef struct packed {
        logic [`CAPTURE_BITS-1:0] tms;
        logic [`CAPTURE_BITS-1:0] tdi;
        logic [`CAPTURE_BITS-1:0] tdo;
    } capture_t;

    typedef struct packed {
        logic                              valid;
        logic [$clog2(`DISPLAY_ROWS)-1:0] row;
        logic [$clog2(`ROW_DIGITS)-1:0]   col;
        logic [3:0]                        nibble;
    } digit_t;

endpackage

// File: verilog/jtag_monitor.sv
`timescale 1ns/100ps
`include "jtag_mon_cfg.svh"

module jtag_monitor (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     tck,
    input  logic                     tms,
    input  logic                     tdi,
    input  jtag_mon_pkg::cfg_wr_t    cfg,
    input  logic                     scan_start,
    output logic                     tdo,
    output jtag_mon_pkg::tap_state_e tap_state,
    output jtag_mon_pkg::digit_t     digit
);
    import jtag_mon_pkg::*;

    jtag_sample_t             smp;
    capture_t                 cap;
    logic [31:0]              idcode;
    logic                     freeze;
    logic                     clear;
    logic [`DISPLAY_BITS-1:0] display;

    jtag_pad_sync jtag_pad_sync_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .tck    (tck),
        .tms    (tms),
        .tdi    (tdi),
        .smp    (smp)
    );

    mon_ctrl_regs mon_ctrl_regs_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .cfg    (cfg),
        .idcode (idcode),
        .freeze (freeze),
        .clear  (clear)
    );

    // test target answering IDCODE and BYPASS
    jtag_tap jtag_tap_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .smp       (smp),
        .idcode    (idcode),
        .tdo       (tdo),
        .tap_state (tap_state)
    );

    capture_bank capture_bank_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .smp    (smp),
        .tdo    (tdo), // target response is recorded too
        .freeze (freeze),
        .clear  (clear),
        .cap    (cap)
    );

    display_compose display_compose_inst (
        .cap       (cap),
        .tap_state (tap_state),
        .display   (display)
    );

    digit_scan digit_scan_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .display    (display),
        .scan_start (scan_start),
        .digit      (digit)
    );

endmodule

// File: verilog/jtag_pad_sync.sv
`timescale 1ns/100ps

module jtag_pad_sync (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      tck,
    input  logic                      tms,
    input  logic                      tdi,
    output jtag_mon_pkg::jtag_sample_t smp
);

    logic [2:0] tck_q; // [0] meta, [1] sync, [2] previous sync
    logic [1:0] tms_q;
    logic [1:0] tdi_q;
    logic       rise_q;
    logic       fall_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tck_q  <= '0;
            tms_q  <= '0;
            tdi_q  <= '0;
            rise_q <= 1'b0;
            fall_q <= 1'b0;
        end else begin
            tck_q  <= {tck_q[1:0], tck};
            tms_q  <= {tms_q[0], tms};
            tdi_q  <= {tdi_q[0], tdi};
            rise_q <= tck_q[1] & ~tck_q[2]; // one cycle per edge
            fall_q <= ~tck_q[1] & tck_q[2];
        end
    end

    assign smp.tck_rise = rise_q;
    assign smp.tck_fall = fall_q;
    assign smp.tms      = tms_q[1];
    assign smp.tdi      = tdi_q[1];

endmodule

// File: verilog/jtag_tap.sv
`timescale 1ns/100ps
`include "jtag_mon_cfg.svh"

module jtag_tap (
    input  logic                      clk,
    input  logic                      arst_n,
    input  jtag_mon_pkg::jtag_sample_t smp,
    input  logic [31:0]               idcode,
    output logic                      tdo,
    output jtag_mon_pkg::tap_state_e  tap_state
);
    import jtag_mon_pkg::*;

    tap_state_e         state_next;
    ir_op_e             ir;
    logic [`IR_LEN-1:0] ir_sr;
    logic [31:0]        dr_sr;
    logic               bypass;
    logic               sel_idcode;

    assign sel_idcode = (ir == IR_IDCODE); // anything else acts as BYPASS

    always_comb begin
        case (tap_state)
            TEST_LOGIC_RESET: state_next = smp.tms ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
            RUN_TEST_IDLE:    state_next = smp.tms ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
            SELECT_DR_SCAN:   state_next = smp.tms ? SELECT_IR_SCAN   : CAPTURE_DR;
            CAPTURE_DR:       state_next = smp.tms ? EXIT1_DR         : SHIFT_DR;
            SHIFT_DR:         state_next = smp.tms ? EXIT1_DR         : SHIFT_DR;
            EXIT1_DR:         state_next = smp.tms ? UPDATE_DR        : PAUSE_DR;
            PAUSE_DR:         state_next = smp.tms ? EXIT2_DR         : PAUSE_DR;
            EXIT2_DR:         state_next = smp.tms ? UPDATE_DR        : SHIFT_DR;
            UPDATE_DR:        state_next = smp.tms ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
            SELECT_IR_SCAN:   state_next = smp.tms ? TEST_LOGIC_RESET : CAPTURE_IR;
            CAPTURE_IR:       state_next = smp.tms ? EXIT1_IR         : SHIFT_IR;
            SHIFT_IR:         state_next = smp.tms ? EXIT1_IR         : SHIFT_IR;
            EXIT1_IR:         state_next = smp.tms ? UPDATE_IR        : PAUSE_IR;
            PAUSE_IR:         state_next = smp.tms ? EXIT2_IR         : PAUSE_IR;
            EXIT2_IR:         state_next = smp.tms ? UPDATE_IR        : SHIFT_IR;
            UPDATE_IR:        state_next = smp.tms ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
            default:          state_next = TEST_LOGIC_RESET;
        endcase
    end

    // state and IR step on the TCK rise strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tap_state <= TEST_LOGIC_RESET;
            ir        <= IR_IDCODE;
        end else if (smp.tck_rise) begin
            tap_state <= state_next;
            if (state_next == TEST_LOGIC_RESET)
                ir <= IR_IDCODE;
            else if (tap_state == UPDATE_IR)
                ir <= ir_op_e'(ir_sr);
        end
    end

    // shift paths, loaded in the capture states before use
    always_ff @(posedge clk) begin
        if (smp.tck_rise) begin
            case (tap_state)
                CAPTURE_IR: ir_sr <= {{(`IR_LEN-1){1'b0}}, 1'b1};
                SHIFT_IR:   ir_sr <= {smp.tdi, ir_sr[`IR_LEN-1:1]}; // LSB goes out first
                CAPTURE_DR: begin
                    dr_sr  <= idcode;
                    bypass <= 1'b0;
                end
                SHIFT_DR: begin
                    if (sel_idcode)
                        dr_sr <= {smp.tdi, dr_sr[31:1]};
                    else
                        bypass <= smp.tdi;
                end
                default: ;
            endcase
        end
    end

    // tdo changes on the falling edge only
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tdo <= 1'b0;
        end else if (smp.tck_fall) begin
            case (tap_state)
                SHIFT_DR: tdo <= sel_idcode ? dr_sr[0] : bypass;
                SHIFT_IR: tdo <= ir_sr[0];
                default:  tdo <= 1'b0;
            endcase
        end
    end

endmodule

// File: verilog/mon_ctrl_regs.sv
`timescale 1ns/100ps
`include "jtag_mon_cfg.svh"

module mon_ctrl_regs (
    input  logic                  clk,
    input  logic                  arst_n,
    input  jtag_mon_pkg::cfg_wr_t cfg,
    output logic [31:0]           idcode,
    output logic                  freeze,
    output logic                  clear
);
    import jtag_mon_pkg::*;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idcode <= `IDCODE_RESET;
            freeze <= 1'b0;
            clear  <= 1'b0;
        end else begin
            clear <= 1'b0; // single cycle pulse
            if (cfg.wr) begin
                case (cfg.addr)
                    CFG_CTRL: begin
                        freeze <= cfg.wdata[0];
                        clear  <= cfg.wdata[1];
                    end
                    CFG_IDCODE: idcode <= cfg.wdata;
                    default: ; // unused address, write dropped
                endcase
            end
        end
    end

endmodule
